// File: Bender.yml
package:
  name: periph_core

sources:
  - files:
      - common/periph_pkg.sv
      - hw/bus/wb_access_fsm.sv
      - hw/timer/timer_counter.sv
      - hw/gpio/gpio_regs.sv
      - hw/button_capture.sv
      - hw/periph_core.sv
  - target: test
    files:
      - tests/periph_checker.sv
      - tests/periph_monitor.sv
      - tests/periph_tb.sv

// File: common/periph_pkg.sv
// Bus widths, address map and register indices; imported by wildcard in every RTL module
`default_nettype none

package periph_pkg;

   localparam int WB_DW     = 32;
   localparam int WB_AW     = 14;
   localparam int SLOT_W    = 4;
   localparam int REG_IDX_W = 2;

   typedef logic [REG_IDX_W-1:0] reg_idx_t;
   typedef logic [WB_DW-1:0]     wb_data_t;

   //*********************************************************************
   // Address map, slot sits above the register index
   //*********************************************************************
   localparam logic [SLOT_W-1:0] SLOT_TIMER  = 4'd0;
   localparam logic [SLOT_W-1:0] SLOT_GPIO   = 4'd1;
   localparam logic [SLOT_W-1:0] SLOT_BUTTON = 4'd2;

   localparam reg_idx_t TMR_CTRL    = 2'd0;
   localparam reg_idx_t TMR_COUNT   = 2'd1;
   localparam reg_idx_t TMR_COMPARE = 2'd2;

   localparam reg_idx_t GPIO_OUT = 2'd0;
   localparam reg_idx_t GPIO_OE  = 2'd1;
   localparam reg_idx_t GPIO_IN  = 2'd2;

   localparam reg_idx_t BTN_LEVEL = 2'd0;
   localparam reg_idx_t BTN_EVENT = 2'd1;
   localparam reg_idx_t BTN_MASK  = 2'd2;

   // Byte selects to bit mask
   function automatic wb_data_t wsel_mask(input logic [WB_DW/8-1:0] sel);
      wb_data_t m;
      for (int b = 0; b < WB_DW/8; b++) begin
         m[8*b +: 8] = {8{sel[b]}};
      end
      return m;
   endfunction

endpackage

`default_nettype wire

// File: hw/bus/wb_access_fsm.sv
// Wishbone slave FSM: decodes slot and index, strobes peripheral writes, returns data with ack
`default_nettype none
`timescale 1ns/1ps

module wb_access_fsm
   import periph_pkg::*;
  (
   input  wire              clk,
   input  wire              i_rst_n,
   input  wire              i_wb_cyc,
   input  wire              i_wb_stb,
   input  wire              i_wb_we,
   input  wire [WB_AW-1:0]  i_wb_adr,
   input  wire wb_data_t    i_wb_dat,
   input  wire [3:0]        i_wb_sel,
   input  wire wb_data_t    i_tmr_rdt,
   input  wire wb_data_t    i_gpio_rdt,
   input  wire wb_data_t    i_btn_rdt,
   output wb_data_t         o_wb_rdt,
   output logic             o_wb_ack,
   output reg_idx_t         o_reg_idx,
   output wb_data_t         o_wdata,
   output logic [3:0]       o_wsel,
   output logic             o_tmr_we,
   output logic             o_gpio_we,
   output logic             o_btn_we
   );

   typedef enum logic {
      ST_IDLE,
      ST_ACK
   } state_t;

   state_t            state;
   logic [SLOT_W-1:0] slot;
   logic              access;
   logic              wr_access;
   wb_data_t          rd_mux;

   //*********************************************************************
   // Address split and write steering
   //*********************************************************************
   assign slot      = i_wb_adr[REG_IDX_W +: SLOT_W];
   assign access    = (state == ST_IDLE) & i_wb_cyc & i_wb_stb;
   assign wr_access = access & i_wb_we;

   assign o_reg_idx = i_wb_adr[REG_IDX_W-1:0];
   assign o_wdata   = i_wb_dat;
   assign o_wsel    = i_wb_sel;

   assign o_tmr_we  = wr_access & (slot == SLOT_TIMER);
   assign o_gpio_we = wr_access & (slot == SLOT_GPIO);
   assign o_btn_we  = wr_access & (slot == SLOT_BUTTON);

   // Unmapped slots read as zero
   always_comb begin
      case (slot)
         SLOT_TIMER:  rd_mux = i_tmr_rdt;
         SLOT_GPIO:   rd_mux = i_gpio_rdt;
         SLOT_BUTTON: rd_mux = i_btn_rdt;
         default:     rd_mux = '0;
      endcase
   end

   //*********************************************************************
   // State and read-data return
   //*********************************************************************
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (access) begin
                  state <= ST_ACK;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         o_wb_rdt <= rd_mux;
      end
   end

   // One cycle, then back to idle
   assign o_wb_ack = (state == ST_ACK);

endmodule

`default_nettype wire

// File: hw/button_capture.sv
// Push-button capture: synchronizes buttons, latches rising edges, raises a masked interrupt
`default_nettype none
`timescale 1ns/1ps

module button_capture
   import periph_pkg::*;
  #(parameter int BUTTON_COUNT = 5)
  (
   input  wire                    clk,
   input  wire                    i_rst_n,
   input  wire                    i_we,
   input  wire reg_idx_t          i_reg_idx,
   input  wire wb_data_t          i_wdata,
   input  wire [3:0]              i_wsel,
   input  wire [BUTTON_COUNT-1:0] i_pb,
   output wb_data_t               o_rdt,
   output logic                   o_button_irq
   );

   logic [BUTTON_COUNT-1:0] pb_meta;
   logic [BUTTON_COUNT-1:0] pb_level;
   logic [BUTTON_COUNT-1:0] pb_prev;
   logic [BUTTON_COUNT-1:0] events;
   logic [BUTTON_COUNT-1:0] mask;
   logic [BUTTON_COUNT-1:0] rise;
   logic [BUTTON_COUNT-1:0] ev_clr;
   wb_data_t                wmask;
   wb_data_t                wmerged;

   assign wmask   = wsel_mask(i_wsel);
   assign wmerged = (o_rdt & ~wmask) | (i_wdata & wmask);
   assign rise    = pb_level & ~pb_prev;
   assign ev_clr  = (i_we && (i_reg_idx == BTN_EVENT)) ?
                    i_wdata[BUTTON_COUNT-1:0] & wmask[BUTTON_COUNT-1:0] : '0;

   always_comb begin
      o_rdt = '0;
      case (i_reg_idx)
         BTN_LEVEL: o_rdt[BUTTON_COUNT-1:0] = pb_level;
         BTN_EVENT: o_rdt[BUTTON_COUNT-1:0] = events;
         BTN_MASK:  o_rdt[BUTTON_COUNT-1:0] = mask;
         default:   o_rdt = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pb_meta  <= '0;
         pb_level <= '0;
         pb_prev  <= '0;
         events   <= '0;
         mask     <= '0;
      end else begin
         pb_meta  <= i_pb;
         pb_level <= pb_meta;
         pb_prev  <= pb_level;
         // New edge beats a clear in the same cycle
         events   <= (events & ~ev_clr) | rise;
         if (i_we && (i_reg_idx == BTN_MASK)) begin
            mask <= wmerged[BUTTON_COUNT-1:0];
         end
      end
   end

   assign o_button_irq = |(events & mask);

endmodule

`default_nettype wire

// File: hw/gpio/gpio_regs.sv
// GPIO register block: output and enable registers, pad tristates, synchronized pad inputs
`default_nettype none
`timescale 1ns/1ps

module gpio_regs
   import periph_pkg::*;
  #(parameter int GPIO_WIDTH = 32)
  (
   input  wire                  clk,
   input  wire                  i_rst_n,
   input  wire                  i_we,
   input  wire reg_idx_t        i_reg_idx,
   input  wire wb_data_t        i_wdata,
   input  wire [3:0]            i_wsel,
   output wb_data_t             o_rdt,
   inout  wire [GPIO_WIDTH-1:0] io_gpio
   );

   logic [GPIO_WIDTH-1:0] out_q;
   logic [GPIO_WIDTH-1:0] oe_q;
   logic [GPIO_WIDTH-1:0] in_meta;
   logic [GPIO_WIDTH-1:0] in_sync;
   wb_data_t              wmask;
   wb_data_t              wmerged;

   assign wmask   = wsel_mask(i_wsel);
   assign wmerged = (o_rdt & ~wmask) | (i_wdata & wmask);

   // Pad cells, released unless enabled
   for (genvar i = 0; i < GPIO_WIDTH; i++) begin : g_pad
      assign io_gpio[i] = oe_q[i] ? out_q[i] : 1'bz;
   end

   always_comb begin
      o_rdt = '0;
      case (i_reg_idx)
         GPIO_OUT: o_rdt[GPIO_WIDTH-1:0] = out_q;
         GPIO_OE:  o_rdt[GPIO_WIDTH-1:0] = oe_q;
         GPIO_IN:  o_rdt[GPIO_WIDTH-1:0] = in_sync;
         default:  o_rdt = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         out_q   <= '0;
         oe_q    <= '0;
         in_meta <= '0;
         in_sync <= '0;
      end else begin
         in_meta <= io_gpio;
         in_sync <= in_meta;
         // GPIO_IN is read only
         if (i_we && (i_reg_idx == GPIO_OUT)) begin
            out_q <= wmerged[GPIO_WIDTH-1:0];
         end
         if (i_we && (i_reg_idx == GPIO_OE)) begin
            oe_q <= wmerged[GPIO_WIDTH-1:0];
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/periph_core.sv
// Peripheral block top: bus slave FSM with timer, GPIO and button capture on shared strobes
`default_nettype none
`timescale 1ns/1ps

module periph_core
   import periph_pkg::*;
  #(parameter int GPIO_WIDTH   = 32,
    parameter int BUTTON_COUNT = 5)
  (
   input  wire                    clk,
   input  wire                    i_rst_n,
   input  wire                    i_wb_cyc,
   input  wire                    i_wb_stb,
   input  wire                    i_wb_we,
   input  wire [WB_AW-1:0]        i_wb_adr,
   input  wire wb_data_t          i_wb_dat,
   input  wire [3:0]              i_wb_sel,
   output wb_data_t               o_wb_rdt,
   output logic                   o_wb_ack,
   inout  wire [GPIO_WIDTH-1:0]   io_gpio,
   input  wire [BUTTON_COUNT-1:0] i_pb,
   output logic                   o_timer_irq,
   output logic                   o_button_irq
   );

   reg_idx_t   reg_idx;
   wb_data_t   wdata;
   logic [3:0] wsel;
   logic       tmr_we;
   logic       gpio_we;
   logic       btn_we;
   wb_data_t   tmr_rdt;
   wb_data_t   gpio_rdt;
   wb_data_t   btn_rdt;

   wb_access_fsm bus_fsm
     (.clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_wb_cyc   (i_wb_cyc),
      .i_wb_stb   (i_wb_stb),
      .i_wb_we    (i_wb_we),
      .i_wb_adr   (i_wb_adr),
      .i_wb_dat   (i_wb_dat),
      .i_wb_sel   (i_wb_sel),
      .i_tmr_rdt  (tmr_rdt),
      .i_gpio_rdt (gpio_rdt),
      .i_btn_rdt  (btn_rdt),
      .o_wb_rdt   (o_wb_rdt),
      .o_wb_ack   (o_wb_ack),
      .o_reg_idx  (reg_idx),
      .o_wdata    (wdata),
      .o_wsel     (wsel),
      .o_tmr_we   (tmr_we),
      .o_gpio_we  (gpio_we),
      .o_btn_we   (btn_we));

   timer_counter timer
     (.clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_we        (tmr_we),
      .i_reg_idx   (reg_idx),
      .i_wdata     (wdata),
      .i_wsel      (wsel),
      .o_rdt       (tmr_rdt),
      .o_timer_irq (o_timer_irq));

   gpio_regs
     #(.GPIO_WIDTH (GPIO_WIDTH))
   gpio
     (.clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_we      (gpio_we),
      .i_reg_idx (reg_idx),
      .i_wdata   (wdata),
      .i_wsel    (wsel),
      .o_rdt     (gpio_rdt),
      .io_gpio   (io_gpio));

   button_capture
     #(.BUTTON_COUNT (BUTTON_COUNT))
   buttons
     (.clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_we         (btn_we),
      .i_reg_idx    (reg_idx),
      .i_wdata      (wdata),
      .i_wsel       (wsel),
      .i_pb         (i_pb),
      .o_rdt        (btn_rdt),
      .o_button_irq (o_button_irq));

endmodule

`default_nettype wire

// File: hw/timer/timer_counter.sv
// Compare timer: enableable up counter with a sticky match interrupt behind three registers
`default_nettype none
`timescale 1ns/1ps

module timer_counter
   import periph_pkg::*;
  (
   input  wire           clk,
   input  wire           i_rst_n,
   input  wire           i_we,
   input  wire reg_idx_t i_reg_idx,
   input  wire wb_data_t i_wdata,
   input  wire [3:0]     i_wsel,
   output wb_data_t      o_rdt,
   output logic          o_timer_irq
   );

   logic     enable;
   logic     pending;
   wb_data_t count;
   wb_data_t compare;
   wb_data_t wmask;
   wb_data_t wmerged;
   wb_data_t wclr;
   logic     match;

   assign wmask   = wsel_mask(i_wsel);
   assign wmerged = (o_rdt & ~wmask) | (i_wdata & wmask);
   assign wclr    = i_wdata & wmask;
   assign match   = enable && (count == compare);

   always_comb begin
      case (i_reg_idx)
         TMR_CTRL:    o_rdt = {{(WB_DW-2){1'b0}}, pending, enable};
         TMR_COUNT:   o_rdt = count;
         TMR_COMPARE: o_rdt = compare;
         default:     o_rdt = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         enable  <= 1'b0;
         pending <= 1'b0;
         count   <= '0;
         compare <= '0;
      end else begin
         if (i_we && (i_reg_idx == TMR_CTRL)) begin
            enable <= wmerged[0];
         end

         // A bus write to the count overrides the increment
         if (i_we && (i_reg_idx == TMR_COUNT)) begin
            count <= wmerged;
         end else if (enable) begin
            count <= count + 1'b1;
         end

         if (i_we && (i_reg_idx == TMR_COMPARE)) begin
            compare <= wmerged;
         end

         // Match wins over write-1 clear
         if (match) begin
            pending <= 1'b1;
         end else if (i_we && (i_reg_idx == TMR_CTRL) && wclr[1]) begin
            pending <= 1'b0;
         end
      end
   end

   assign o_timer_irq = pending;

endmodule

`default_nettype wire

// File: tests/periph_checker.sv
// Ack timing and interrupt reset assertions, bound into periph_core by the testbench
`default_nettype none
`timescale 1ns/1ps

module periph_checker
  (
   input wire clk,
   input wire i_rst_n,
   input wire i_wb_cyc,
   input wire i_wb_stb,
   input wire i_wb_ack,
   input wire i_timer_irq,
   input wire i_button_irq
   );

   logic in_reset_q;
   int   fail_count = 0;

   always @(posedge clk) begin
      in_reset_q <= !i_rst_n;
   end

   ack_one_cycle: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_wb_ack |=> !i_wb_ack)
      else begin
         $error("ack lasted more than one cycle");
         fail_count++;
      end

   ack_after_access: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
      else begin
         $error("ack without an access in the previous cycle");
         fail_count++;
      end

   // Registers are cleared by the first reset edge
   irq_low_in_reset: assert property (@(posedge clk)
      (in_reset_q && !i_rst_n) |-> (!i_timer_irq && !i_button_irq))
      else begin
         $error("interrupt high during reset");
         fail_count++;
      end

   timer_irq_known: assert property (@(posedge clk) disable iff (!i_rst_n)
      !$isunknown(i_timer_irq))
      else begin
         $error("timer interrupt unknown after reset");
         fail_count++;
      end

endmodule

bind periph_core periph_checker chk
  (.clk          (clk),
   .i_rst_n      (i_rst_n),
   .i_wb_cyc     (i_wb_cyc),
   .i_wb_stb     (i_wb_stb),
   .i_wb_ack     (o_wb_ack),
   .i_timer_irq  (o_timer_irq),
   .i_button_irq (o_button_irq));

`default_nettype wire

// File: tests/periph_golden.txt
// Records of four hex words: control, arg1, arg2, arg3. Control bits 3:0 type, 7:4 write selects
// 1 write slot idx data | 2 read slot idx expected | 3 pad value mask | 4 buttons level
// 5 wait cycles | 6 irq timer button | 7 test end name (8 ASCII chars) | f end of records
02 0 0 00000000
02 0 1 00000000
02 0 2 00000000
02 1 0 00000000
02 1 1 00000000
02 1 2 00000000
02 2 0 00000000
02 2 1 00000000
02 2 2 00000000
06 0 0 0
07 7273745f 73746174 0
f1 0 2 a5a51234
02 0 2 a5a51234
31 0 2 0000beef
02 0 2 a5a5beef
f1 1 0 12345678
02 1 0 12345678
41 1 0 00ff0000
02 1 0 12ff5678
f1 1 1 0000ffff
02 1 1 0000ffff
f1 2 2 ffffffff
02 2 2 0000001f
f1 2 2 00000000
02 2 2 00000000
f1 3 0 deadbeef
02 3 0 00000000
02 0 0 00000000
02 1 0 12ff5678
07 72656164 6261636b 0
03 a5c30000 ffff0000 0
05 3 0 0
02 1 2 a5c35678
f1 1 0 00001111
05 3 0 0
02 1 2 a5c31111
03 0f0f0000 ffff0000 0
05 3 0 0
02 1 2 0f0f1111
03 0 0 0
f1 1 1 00000000
05 3 0 0
02 1 2 00000000
02 1 1 00000000
07 6770696f 5f706164 0
f1 0 1 00001234
05 4 0 0
02 0 1 00001234
f1 0 1 00000000
f1 0 2 00000014
f1 0 0 00000001
05 1e 0 0
02 0 0 00000003
06 1 0 0
f1 0 0 00000003
02 0 0 00000001
06 0 0 0
f1 0 0 00000000
02 0 0 00000000
07 74696d65 72202020 0
f1 2 2 00000001
04 3 0 0
05 5 0 0
02 2 0 00000003
02 2 1 00000003
06 0 1 0
f1 2 1 00000001
02 2 1 00000002
06 0 0 0
f1 2 2 00000003
06 0 1 0
f1 2 1 00000002
02 2 1 00000000
06 0 0 0
04 0 0 0
05 5 0 0
02 2 0 00000000
02 2 1 00000000
06 0 0 0
04 10 0 0
05 5 0 0
02 2 0 00000010
02 2 1 00000010
06 0 0 0
07 62757474 6f6e7320 0
0f 0 0 0

// File: tests/periph_monitor.sv
// Testbench monitor: compares read data and interrupt levels with expected values, prints results
`default_nettype none
`timescale 1ns/1ps

module periph_monitor
  (
   input  wire        clk,
   input  wire        i_rst_n,
   input  wire        i_wb_cyc,
   input  wire        i_wb_stb,
   input  wire        i_wb_ack,
   input  wire [31:0] i_wb_rdt,
   input  wire        i_timer_irq,
   input  wire        i_button_irq,
   input  wire        i_exp_valid,
   input  wire [31:0] i_exp_rdt,
   input  wire        i_irq_chk,
   input  wire        i_exp_timer_irq,
   input  wire        i_exp_button_irq,
   input  wire        i_test_done,
   input  wire [63:0] i_test_name,
   input  wire        i_run_done,
   output int         o_error_count
   );

   int errors       = 0;
   int test_errors  = 0;
   int checks       = 0;
   int tests_run    = 0;
   int tests_failed = 0;
   int stall        = 0;

   assign o_error_count = errors;

   always @(posedge clk) begin
      // Ack must come within 4 cycles of stb
      if (i_rst_n && i_wb_cyc && i_wb_stb && !i_wb_ack) begin
         stall++;
         if (stall == 4) begin
            $display("Bus access got no ack within 4 cycles of stb");
            errors++;
            test_errors++;
         end
      end else begin
         stall = 0;
      end

      if (i_wb_ack && i_exp_valid) begin
         checks++;
         if (i_wb_rdt !== i_exp_rdt) begin
            $display("Fail o_wb_rdt: expected %08h, got %08h", i_exp_rdt, i_wb_rdt);
            errors++;
            test_errors++;
         end
      end

      if (i_irq_chk) begin
         checks += 2;
         if (i_timer_irq !== i_exp_timer_irq) begin
            $display("Fail o_timer_irq: expected %h, got %h", i_exp_timer_irq, i_timer_irq);
            errors++;
            test_errors++;
         end
         if (i_button_irq !== i_exp_button_irq) begin
            $display("Fail o_button_irq: expected %h, got %h", i_exp_button_irq, i_button_irq);
            errors++;
            test_errors++;
         end
      end

      if (i_test_done) begin
         tests_run++;
         if (test_errors == 0) begin
            $display("Test %s passed", i_test_name);
         end else begin
            $display("Test %s failed with %0d errors", i_test_name, test_errors);
            tests_failed++;
         end
         test_errors = 0;
      end

      if (i_run_done) begin
         $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                  tests_run, tests_failed, checks, errors);
      end
   end

endmodule

`default_nettype wire

// File: tests/periph_tb.sv
// Testbench top that replays the golden stimulus records against periph_core
`default_nettype none
`timescale 1ns/1ps

module periph_tb;

   localparam int CLK_PERIOD = 8;
   localparam int RST_CYCLES = 10;
   localparam int MEM_WORDS  = 1024;
   localparam int ACK_LIMIT  = 8;

   // Record type in the low nibble of the control word
   localparam logic [3:0] OP_WRITE    = 4'h1;
   localparam logic [3:0] OP_READ     = 4'h2;
   localparam logic [3:0] OP_PAD      = 4'h3;
   localparam logic [3:0] OP_BUTTON   = 4'h4;
   localparam logic [3:0] OP_WAIT     = 4'h5;
   localparam logic [3:0] OP_IRQ      = 4'h6;
   localparam logic [3:0] OP_TEST_END = 4'h7;
   localparam logic [3:0] OP_END      = 4'hf;

   logic        clk;
   logic        rst_n;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [13:0] wb_adr;
   logic [31:0] wb_dat;
   logic [3:0]  wb_sel;
   logic [31:0] wb_rdt;
   logic        wb_ack;
   logic [4:0]  pb;
   logic        timer_irq;
   logic        button_irq;
   tri0  [31:0] gpio_pads;
   logic [31:0] pad_val;
   logic [31:0] pad_mask;

   logic        exp_valid;
   logic [31:0] exp_rdt;
   logic        irq_chk;
   logic        exp_timer_irq;
   logic        exp_button_irq;
   logic        test_done;
   logic [63:0] test_name;
   logic        run_done;
   int          error_count;
   int          load_errors;

   logic [31:0] golden [0:MEM_WORDS-1];
   int          rec_count;
   int unsigned wd_cycles = 0;

   initial clk = 1'b0;

   always begin
      #(CLK_PERIOD/2) clk = ~clk;
   end

   // Testbench pad drivers on masked bits only
   for (genvar i = 0; i < 32; i++) begin : g_pad_drv
      assign gpio_pads[i] = pad_mask[i] ? pad_val[i] : 1'bz;
   end

   periph_core UUT
     (.clk          (clk),
      .i_rst_n      (rst_n),
      .i_wb_cyc     (wb_cyc),
      .i_wb_stb     (wb_stb),
      .i_wb_we      (wb_we),
      .i_wb_adr     (wb_adr),
      .i_wb_dat     (wb_dat),
      .i_wb_sel     (wb_sel),
      .o_wb_rdt     (wb_rdt),
      .o_wb_ack     (wb_ack),
      .io_gpio      (gpio_pads),
      .i_pb         (pb),
      .o_timer_irq  (timer_irq),
      .o_button_irq (button_irq));

   periph_monitor mon
     (.clk              (clk),
      .i_rst_n          (rst_n),
      .i_wb_cyc         (wb_cyc),
      .i_wb_stb         (wb_stb),
      .i_wb_ack         (wb_ack),
      .i_wb_rdt         (wb_rdt),
      .i_timer_irq      (timer_irq),
      .i_button_irq     (button_irq),
      .i_exp_valid      (exp_valid),
      .i_exp_rdt        (exp_rdt),
      .i_irq_chk        (irq_chk),
      .i_exp_timer_irq  (exp_timer_irq),
      .i_exp_button_irq (exp_button_irq),
      .i_test_done      (test_done),
      .i_test_name      (test_name),
      .i_run_done       (run_done),
      .o_error_count    (error_count));

   //*********************************************************************
   // Driver tasks change inputs 1 ns after the rising edge
   //*********************************************************************
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic idle_gap();
      int gap;
      gap = $urandom_range(3, 0);
      repeat (gap) next_cycle();
   endtask

   task automatic bus_access(input logic we, input logic [3:0] slot, input logic [1:0] idx,
                             input logic [3:0] sel, input logic [31:0] data);
      int waited;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = we;
      wb_adr = {8'd0, slot, idx};
      wb_dat = data;
      wb_sel = sel;
      waited = 0;
      // Give up after ACK_LIMIT cycles
      do begin
         @(posedge clk);
         waited++;
      end while (!wb_ack && waited < ACK_LIMIT);
      #1;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      exp_valid = 1'b0;
   endtask

   task automatic read_expect(input logic [3:0] slot, input logic [1:0] idx,
                              input logic [31:0] expected);
      exp_rdt   = expected;
      exp_valid = 1'b1;
      bus_access(1'b0, slot, idx, 4'h0, 32'h0);
   endtask

   // Watchdog armed once the record count is known
   initial begin
      wait (wd_cycles != 0);
      #(wd_cycles * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d cycles", wd_cycles);
      $display("Errors found");
      $finish;
   end

   initial begin
      logic [7:0]  ctl;
      logic [31:0] arg_a;
      logic [31:0] arg_b;
      logic [31:0] arg_c;
      int unsigned wait_sum;

      rst_n          = 1'b0;
      wb_cyc         = 1'b0;
      wb_stb         = 1'b0;
      wb_we          = 1'b0;
      wb_adr         = '0;
      wb_dat         = '0;
      wb_sel         = '0;
      pb             = '0;
      pad_val        = '0;
      pad_mask       = '0;
      exp_valid      = 1'b0;
      exp_rdt        = '0;
      irq_chk        = 1'b0;
      exp_timer_irq  = 1'b0;
      exp_button_irq = 1'b0;
      test_done      = 1'b0;
      test_name      = '0;
      run_done       = 1'b0;
      load_errors    = 0;
      void'($urandom(32'h8dc6_4b1e));

      $readmemh("tests/periph_golden.txt", golden);
      rec_count = 0;
      wait_sum  = 0;
      for (int r = 0; r < MEM_WORDS/4; r++) begin
         if ($isunknown(golden[4*r]) || golden[4*r][3:0] == OP_END) begin
            break;
         end
         rec_count++;
         if (golden[4*r][3:0] == OP_WAIT) begin
            wait_sum += golden[4*r+1];
         end
      end
      if (rec_count == 0) begin
         $display("The stimulus file holds no records");
         load_errors++;
      end
      wd_cycles = rec_count * 8 + wait_sum + 200;

      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;

      for (int r = 0; r < rec_count; r++) begin
         ctl   = golden[4*r][7:0];
         arg_a = golden[4*r+1];
         arg_b = golden[4*r+2];
         arg_c = golden[4*r+3];
         case (ctl[3:0])
            OP_WRITE: begin
               idle_gap();
               bus_access(1'b1, arg_a[3:0], arg_b[1:0], ctl[7:4], arg_c);
            end
            OP_READ: begin
               idle_gap();
               read_expect(arg_a[3:0], arg_b[1:0], arg_c);
            end
            OP_PAD: begin
               pad_val  = arg_a;
               pad_mask = arg_b;
            end
            OP_BUTTON: begin
               pb = arg_a[4:0];
            end
            OP_WAIT: begin
               repeat (arg_a) next_cycle();
            end
            OP_IRQ: begin
               exp_timer_irq  = arg_a[0];
               exp_button_irq = arg_b[0];
               irq_chk        = 1'b1;
               next_cycle();
               irq_chk        = 1'b0;
            end
            OP_TEST_END: begin
               test_name = {arg_a, arg_b};
               test_done = 1'b1;
               next_cycle();
               test_done = 1'b0;
            end
            default: begin
               $display("Unknown record type %0h at record %0d", ctl[3:0], r);
               load_errors++;
            end
         endcase
      end

      run_done = 1'b1;
      next_cycle();
      run_done = 1'b0;

      if (error_count == 0 && load_errors == 0 && UUT.chk.fail_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
common/periph_pkg.sv
hw/bus/wb_access_fsm.sv
hw/timer/timer_counter.sv
hw/gpio/gpio_regs.sv
hw/button_capture.sv
hw/periph_core.sv
tests/periph_checker.sv
tests/periph_monitor.sv
tests/periph_tb.sv
